// ==== run_sim.sh ====
#!/bin/sh
# build and run the sonata testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module sonata_tb \
    -f sonata.f -Mdir obj_dir -o sonata_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sonata_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sonata.f ====
+incdir+source
source/sonata_pkg.sv
source/uart_cmd_link.sv
source/reg_bank.sv
source/lb_mem_test.sv
source/lb_sram.sv
source/led_status.sv
source/sonata_top.sv
testbench/sonata_tb.sv

// ==== source/lb_mem_test.sv ====
// lb_mem_test: write-then-read memory test with pass/fail and error counting
`include "sonata_settings.svh"

module lb_mem_test (
    input  logic       mainclk_buf,
    input  logic       reset_i,
    input  logic       active_i,
    input  logic       check_i,
    input  logic       clear_fail_i,
    input  logic       lfsr_mode_i,
    input  logic [7:0] addr_start_i,
    input  logic [7:0] addr_stop_i,
    output logic       pass_o,
    output logic       fail_o,
    output logic       busy_o,
    output logic [7:0] errors_o,
    output logic [7:0] iterations_o,
    lb_if.host         lb
);
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_WRITE = 2'd1;
    localparam logic [1:0] S_READ  = 2'd2;
    localparam logic [1:0] S_CMP   = 2'd3;

    logic [1:0]                   state;
    logic [`SONATA_LB_ADDR_W-1:0] addr;
    logic [`SONATA_LB_DATA_W-1:0] lfsr;
    logic [`SONATA_LB_DATA_W-1:0] lfsr_next;
    logic [`SONATA_LB_DATA_W-1:0] pattern;
    logic                         run_bad;   // error seen in this run
    logic                         mismatch;

    assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ `SONATA_LFSR_TAPS) : (lfsr >> 1);
    assign pattern   = lfsr_mode_i ? lfsr : {~addr, addr};
    assign mismatch  = lb.rd_rdy && (lb.rd_d != pattern);
    assign busy_o    = (state != S_IDLE);
    assign lb.wr     = (state == S_WRITE);
    assign lb.rd     = (state == S_READ);
    assign lb.addr   = addr;
    assign lb.wr_d   = pattern;

    always_ff @(posedge mainclk_buf) begin
        if (reset_i) begin
            state        <= S_IDLE;
            pass_o       <= 1'b0;
            fail_o       <= 1'b0;
            errors_o     <= '0;
            iterations_o <= '0;
            run_bad      <= 1'b0;
        end else begin
            if (clear_fail_i) begin
                fail_o   <= 1'b0;
                errors_o <= '0;
            end
            case (state)
                S_IDLE: begin
                    if (check_i && active_i && addr_start_i <= addr_stop_i) begin
                        state   <= S_WRITE;
                        pass_o  <= 1'b0;
                        run_bad <= 1'b0;
                    end
                end
                S_WRITE: if (addr == addr_stop_i) state <= S_READ;
                S_READ:  state <= S_CMP;
                default: begin
                    if (lb.rd_rdy) begin
                        if (mismatch) begin
                            run_bad <= 1'b1;
                            if (errors_o != 8'hFF)
                                errors_o <= errors_o + 1'b1;
                        end
                        if (addr == addr_stop_i) begin   // last word checked
                            state        <= S_IDLE;
                            pass_o       <= ~(run_bad | mismatch);
                            fail_o       <= fail_o | run_bad | mismatch;
                            iterations_o <= iterations_o + 1'b1;
                        end else begin
                            state <= S_READ;
                        end
                    end
                end
            endcase
        end
    end

    // address walk and pattern generator, reseeded for the read pass
    always_ff @(posedge mainclk_buf) begin
        case (state)
            S_IDLE: begin
                addr <= addr_start_i;
                lfsr <= `SONATA_LFSR_SEED;
            end
            S_WRITE: begin
                addr <= (addr == addr_stop_i) ? addr_start_i : addr + 1'b1;
                lfsr <= (addr == addr_stop_i) ? `SONATA_LFSR_SEED : lfsr_next;
            end
            S_CMP: begin
                if (lb.rd_rdy) begin
                    addr <= addr + 1'b1;
                    lfsr <= lfsr_next;
                end
            end
            default: ;
        endcase
    end

    a_addr_in_range: assert property (@(posedge mainclk_buf) disable iff (reset_i)
        busy_o |-> (addr >= addr_start_i && addr <= addr_stop_i));

endmodule

// ==== source/lb_sram.sv ====
// lb_sram: 256 x 16 local-bus memory with manual/automatic host selection
`include "sonata_settings.svh"

module lb_sram (
    input  logic mainclk_buf,
    input  logic reset_i,
    input  logic manual_i,
    lb_if.target man,
    lb_if.target auto
);
    logic [`SONATA_LB_DATA_W-1:0] mem [0:`SONATA_LB_DEPTH-1];
    logic                         sel_wr;
    logic                         sel_rd;
    logic [`SONATA_LB_ADDR_W-1:0] sel_addr;
    logic [`SONATA_LB_DATA_W-1:0] sel_wr_d;
    logic [`SONATA_LB_DATA_W-1:0] rd_data;
    logic                         rd_rdy;

    assign sel_wr   = manual_i ? man.wr   : auto.wr;
    assign sel_rd   = manual_i ? man.rd   : auto.rd;
    assign sel_addr = manual_i ? man.addr : auto.addr;
    assign sel_wr_d = manual_i ? man.wr_d : auto.wr_d;

    always_ff @(posedge mainclk_buf) begin
        if (sel_wr)
            mem[sel_addr] <= sel_wr_d;
        rd_data <= mem[sel_addr];   // valid the cycle after rd
    end

    always_ff @(posedge mainclk_buf) begin
        if (reset_i)
            rd_rdy <= 1'b0;
        else
            rd_rdy <= sel_rd;
    end

    // both hosts see the same read return
    assign man.rd_d    = rd_data;
    assign auto.rd_d   = rd_data;
    assign man.rd_rdy  = rd_rdy;
    assign auto.rd_rdy = rd_rdy;

    a_no_wr_rd: assert property (@(posedge mainclk_buf) disable iff (reset_i)
        !(sel_wr && sel_rd));

endmodule

// ==== source/led_status.sv ====
// led_status: heartbeat counter and LED output selection
`include "sonata_settings.svh"

module led_status import sonata_pkg::*; (
    input  logic       mainclk_buf,
    input  logic       reset_i,
    input  logic       test_mode_i,
    input  logic       flash_all_i,
    input  logic       user_led_i,
    input  logic       lb_manual_i,
    input  logic       pass_i,
    input  logic       fail_i,
    input  logic       busy_i,
    input  logic       framing_error_i,
    input  led_word_u  test_leds_i,
    output logic [7:0] usrled_o,
    output logic [8:0] cherierr_o,
    output logic       led_legacy_o,
    output logic       led_cheri_o,
    output logic       led_halted_o,
    output logic       led_bootok_o
);
    localparam int HB_W = `SONATA_HEARTBEAT_W;

    logic [HB_W-1:0] heartbeat;
    led_word_u       shown;

    always_ff @(posedge mainclk_buf) begin
        if (reset_i)
            heartbeat <= '0;
        else
            heartbeat <= heartbeat + 1'b1;
    end

    always_comb begin
        if (test_mode_i) begin
            shown.raw = flash_all_i ? {21{heartbeat[HB_W-2]}} : test_leds_i.raw;
        end else begin
            shown.raw           = '0;
            shown.fields.usrled = {framing_error_i, busy_i, reset_i, pass_i,
                                   fail_i, lb_manual_i, user_led_i, heartbeat[HB_W-1]};
        end
    end

    assign usrled_o     = shown.fields.usrled;
    assign cherierr_o   = shown.fields.cherierr;
    assign led_legacy_o = shown.fields.legacy;
    assign led_cheri_o  = shown.fields.cheri;
    assign led_halted_o = shown.fields.halted;
    assign led_bootok_o = shown.fields.bootok;

endmodule

// ==== source/reg_bank.sv ====
// reg_bank: register map, control pulses, manual local-bus window and read mux
`include "sonata_settings.svh"

module reg_bank import sonata_pkg::*; (
    input  logic        mainclk_buf,
    input  logic        reset_i,
    reg_if.slave        bus,
    lb_if.host          lb,
    input  logic [15:0] switches_i,
    input  logic        auto_pass_i,
    input  logic        auto_fail_i,
    input  logic        auto_busy_i,
    input  logic [7:0]  auto_errors_i,
    input  logic [7:0]  auto_iterations_i,
    output logic        user_led_o,
    output logic        led_test_mode_o,
    output logic        led_flash_all_o,
    output logic        lb_manual_o,
    output logic        check_o,
    output logic        clear_fail_o,
    output logic        lfsr_mode_o,
    output led_word_u   test_leds_o,
    output logic [7:0]  addr_start_o,
    output logic [7:0]  addr_stop_o
);
    logic [15:0] man_rdata;   // last manual read word

    always_ff @(posedge mainclk_buf) begin
        if (reset_i) begin
            user_led_o      <= 1'b0;
            led_test_mode_o <= 1'b0;
            led_flash_all_o <= 1'b0;
            lb_manual_o     <= 1'b1;   // host owns the memory out of reset
            lfsr_mode_o     <= 1'b0;
            check_o         <= 1'b0;
            clear_fail_o    <= 1'b0;
            lb.wr           <= 1'b0;
            lb.rd           <= 1'b0;
        end else begin
            check_o      <= 1'b0;   // pulses last one cycle
            clear_fail_o <= 1'b0;
            lb.wr        <= 1'b0;
            lb.rd        <= 1'b0;
            if (bus.reg_write && bus.reg_address == `SONATA_REG_CTRL) begin
                user_led_o      <= bus.write_data[0];
                led_test_mode_o <= bus.write_data[1];
                led_flash_all_o <= bus.write_data[2];
                lb_manual_o     <= bus.write_data[3];
                check_o         <= bus.write_data[4];
                clear_fail_o    <= bus.write_data[5];
                lfsr_mode_o     <= bus.write_data[6];
            end
            if (bus.reg_write && bus.reg_address == `SONATA_REG_MAN_CMD) begin
                lb.wr <= bus.write_data[0];
                lb.rd <= bus.write_data[1] & ~bus.write_data[0];   // write wins
            end
        end
    end

    always_ff @(posedge mainclk_buf) begin
        if (bus.reg_write) begin
            case (bus.reg_address)
                `SONATA_REG_LED0:         test_leds_o.raw[7:0]   <= bus.write_data;
                `SONATA_REG_LED1:         test_leds_o.raw[15:8]  <= bus.write_data;
                `SONATA_REG_LED2:         test_leds_o.raw[20:16] <= bus.write_data[4:0];
                `SONATA_REG_ADDR_START:   addr_start_o           <= bus.write_data;
                `SONATA_REG_ADDR_STOP:    addr_stop_o            <= bus.write_data;
                `SONATA_REG_MAN_ADDR:     lb.addr                <= bus.write_data;
                `SONATA_REG_MAN_WDATA_LO: lb.wr_d[7:0]           <= bus.write_data;
                `SONATA_REG_MAN_WDATA_HI: lb.wr_d[15:8]          <= bus.write_data;
                default: ;
            endcase
        end
        if (lb.rd_rdy && lb_manual_o)   // auto test reads are not captured
            man_rdata <= lb.rd_d;
    end

    always_comb begin
        case (bus.reg_address)
            `SONATA_REG_ID:           bus.read_data = `SONATA_ID;
            `SONATA_REG_CTRL:         bus.read_data = {1'b0, lfsr_mode_o, 2'b00, lb_manual_o,
                                                       led_flash_all_o, led_test_mode_o,
                                                       user_led_o};
            `SONATA_REG_LED0:         bus.read_data = test_leds_o.raw[7:0];
            `SONATA_REG_LED1:         bus.read_data = test_leds_o.raw[15:8];
            `SONATA_REG_LED2:         bus.read_data = {3'b000, test_leds_o.raw[20:16]};
            `SONATA_REG_STATUS:       bus.read_data = {5'b0, auto_busy_i, auto_fail_i,
                                                       auto_pass_i};
            `SONATA_REG_ADDR_START:   bus.read_data = addr_start_o;
            `SONATA_REG_ADDR_STOP:    bus.read_data = addr_stop_o;
            `SONATA_REG_ERRORS:       bus.read_data = auto_errors_i;
            `SONATA_REG_ITERATIONS:   bus.read_data = auto_iterations_i;
            `SONATA_REG_MAN_ADDR:     bus.read_data = lb.addr;
            `SONATA_REG_MAN_WDATA_LO: bus.read_data = lb.wr_d[7:0];
            `SONATA_REG_MAN_WDATA_HI: bus.read_data = lb.wr_d[15:8];
            `SONATA_REG_MAN_RDATA_LO: bus.read_data = man_rdata[7:0];
            `SONATA_REG_MAN_RDATA_HI: bus.read_data = man_rdata[15:8];
            `SONATA_REG_SW_LO:        bus.read_data = switches_i[7:0];
            `SONATA_REG_SW_HI:        bus.read_data = switches_i[15:8];
            default:                  bus.read_data = 8'h00;
        endcase
    end

endmodule

// ==== source/sonata_pkg.sv ====
// sonata_pkg types, register bus interface reg_if and local bus interface lb_if
`include "sonata_settings.svh"

package sonata_pkg;

    typedef logic [6:0] reg_addr_t;

    // LED word, filled raw by three host registers, shown as fields
    typedef union packed {
        logic [20:0] raw;
        struct packed {
            logic       bootok;
            logic       halted;
            logic       cheri;
            logic       legacy;
            logic [8:0] cherierr;
            logic [7:0] usrled;
        } fields;
    } led_word_u;

endpackage

interface reg_if import sonata_pkg::*; ();
    reg_addr_t  reg_address;
    logic [7:0] write_data;
    logic [7:0] read_data;   // combinational, valid while reg_read is high
    logic       reg_read;
    logic       reg_write;

    modport master (output reg_address, write_data, reg_read, reg_write, input read_data);
    modport slave (input reg_address, write_data, reg_read, reg_write, output read_data);
endinterface

interface lb_if;
    logic                          wr;
    logic                          rd;
    logic [`SONATA_LB_ADDR_W-1:0]  addr;
    logic [`SONATA_LB_DATA_W-1:0]  wr_d;
    logic [`SONATA_LB_DATA_W-1:0]  rd_d;
    logic                          rd_rdy;   // one cycle after rd

    modport host (output wr, rd, addr, wr_d, input rd_d, rd_rdy);
    modport target (input wr, rd, addr, wr_d, output rd_d, rd_rdy);
endinterface

// ==== source/sonata_settings.svh ====
// bit rate, bus widths, memory depth, register addresses, ID value and LFSR constants
`ifndef SONATA_SETTINGS_SVH
`define SONATA_SETTINGS_SVH

`define SONATA_BIT_RATE     8          // clocks per UART bit
`define SONATA_LB_ADDR_W    8
`define SONATA_LB_DATA_W    16
`define SONATA_LB_DEPTH     256
`define SONATA_HEARTBEAT_W  24
`define SONATA_ID           8'h5A
`define SONATA_LFSR_SEED    16'hACE1
`define SONATA_LFSR_TAPS    16'hB400   // x^16+x^14+x^13+x^11+1, galois form

`define SONATA_REG_ID           7'h00
`define SONATA_REG_CTRL         7'h01
`define SONATA_REG_LED0         7'h02
`define SONATA_REG_LED1         7'h03
`define SONATA_REG_LED2         7'h04
`define SONATA_REG_STATUS       7'h05
`define SONATA_REG_ADDR_START   7'h06
`define SONATA_REG_ADDR_STOP    7'h07
`define SONATA_REG_ERRORS       7'h08
`define SONATA_REG_ITERATIONS   7'h09
`define SONATA_REG_MAN_ADDR     7'h0A
`define SONATA_REG_MAN_WDATA_LO 7'h0B
`define SONATA_REG_MAN_WDATA_HI 7'h0C
`define SONATA_REG_MAN_CMD      7'h0D
`define SONATA_REG_MAN_RDATA_LO 7'h0E
`define SONATA_REG_MAN_RDATA_HI 7'h0F
`define SONATA_REG_SW_LO        7'h10
`define SONATA_REG_SW_HI        7'h11

`endif

// ==== source/sonata_top.sv ====
// sonata_top: board ports, bus interfaces and the board test core instances
module sonata_top import sonata_pkg::*; (
    input  logic       mainclk_buf,
    input  logic       reset_i,
    input  logic       ss2_rx_i,
    output logic       ss2_tx_o,
    input  logic [7:0] usrsw_i,
    input  logic [4:0] navsw_i,
    input  logic [2:0] selsw_i,
    output logic [7:0] usrled_o,
    output logic [8:0] cherierr_o,
    output logic       led_legacy_o,
    output logic       led_cheri_o,
    output logic       led_halted_o,
    output logic       led_bootok_o
);
    logic       framing_error;
    logic       user_led;
    logic       led_test_mode;
    logic       led_flash_all;
    logic       lb_manual;
    logic       check;
    logic       clear_fail;
    logic       lfsr_mode;
    logic       auto_pass;
    logic       auto_fail;
    logic       auto_busy;
    logic [7:0] auto_errors;
    logic [7:0] auto_iterations;
    logic [7:0] addr_start;
    logic [7:0] addr_stop;
    led_word_u  test_leds;

    reg_if reg_bus ();
    lb_if  lb_man ();    // host side is reg_bank
    lb_if  lb_auto ();   // host side is the test engine

    uart_cmd_link uart_cmd_link_i (
        .mainclk_buf, .reset_i, .rx_i(ss2_rx_i), .tx_o(ss2_tx_o),
        .framing_error_o(framing_error), .bus(reg_bus)
    );

    reg_bank reg_bank_i (
        .mainclk_buf, .reset_i, .bus(reg_bus), .lb(lb_man),
        .switches_i({usrsw_i, navsw_i, selsw_i}),
        .auto_pass_i(auto_pass), .auto_fail_i(auto_fail), .auto_busy_i(auto_busy),
        .auto_errors_i(auto_errors), .auto_iterations_i(auto_iterations),
        .user_led_o(user_led), .led_test_mode_o(led_test_mode),
        .led_flash_all_o(led_flash_all), .lb_manual_o(lb_manual), .check_o(check),
        .clear_fail_o(clear_fail), .lfsr_mode_o(lfsr_mode), .test_leds_o(test_leds),
        .addr_start_o(addr_start), .addr_stop_o(addr_stop)
    );

    lb_mem_test lb_mem_test_i (
        .mainclk_buf, .reset_i, .active_i(~lb_manual), .check_i(check),
        .clear_fail_i(clear_fail), .lfsr_mode_i(lfsr_mode),
        .addr_start_i(addr_start), .addr_stop_i(addr_stop),
        .pass_o(auto_pass), .fail_o(auto_fail), .busy_o(auto_busy),
        .errors_o(auto_errors), .iterations_o(auto_iterations), .lb(lb_auto)
    );

    lb_sram lb_sram_i (
        .mainclk_buf, .reset_i, .manual_i(lb_manual), .man(lb_man), .auto(lb_auto)
    );

    led_status led_status_i (
        .mainclk_buf, .reset_i, .test_mode_i(led_test_mode), .flash_all_i(led_flash_all),
        .user_led_i(user_led), .lb_manual_i(lb_manual), .pass_i(auto_pass),
        .fail_i(auto_fail), .busy_i(auto_busy), .framing_error_i(framing_error),
        .test_leds_i(test_leds), .usrled_o, .cherierr_o, .led_legacy_o,
        .led_cheri_o, .led_halted_o, .led_bootok_o
    );

endmodule

// ==== source/uart_cmd_link.sv ====
// uart_cmd_link: 8N1 receiver, reply transmitter and two-byte command framing
`include "sonata_settings.svh"

module uart_cmd_link (
    input  logic  mainclk_buf,
    input  logic  reset_i,
    input  logic  rx_i,
    output logic  tx_o,
    output logic  framing_error_o,
    reg_if.master bus
);
    localparam int BIT_CLKS = `SONATA_BIT_RATE;
    localparam int CNT_W    = $clog2(BIT_CLKS) + 1;

    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    logic [1:0]       rx_sync;
    logic             rx_in;
    logic [1:0]       rx_state;
    logic [CNT_W-1:0] rx_cnt;
    logic [2:0]       rx_bits;
    logic [7:0]       rx_shift;
    logic             pending_write;   // command seen, data byte next
    logic [9:0]       tx_shift;        // stop, data, start
    logic [CNT_W-1:0] tx_cnt;
    logic [3:0]       tx_left;

    assign rx_in = rx_sync[1];
    assign tx_o  = tx_shift[0];

    always_ff @(posedge mainclk_buf) begin
        if (reset_i) begin
            rx_sync         <= 2'b11;
            rx_state        <= RX_IDLE;
            rx_cnt          <= '0;
            rx_bits         <= '0;
            pending_write   <= 1'b0;
            framing_error_o <= 1'b0;
            bus.reg_read    <= 1'b0;
            bus.reg_write   <= 1'b0;
        end else begin
            rx_sync       <= {rx_sync[0], rx_i};
            bus.reg_read  <= 1'b0;
            bus.reg_write <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_in)
                        rx_state <= RX_START;
                end
                RX_START: begin   // recheck start bit at mid-bit
                    if (rx_cnt == CNT_W'(BIT_CLKS / 2 - 1)) begin
                        rx_cnt   <= '0;
                        rx_bits  <= '0;
                        rx_state <= rx_in ? RX_IDLE : RX_DATA;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == CNT_W'(BIT_CLKS - 1)) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_in, rx_shift[7:1]};   // lsb first
                        rx_bits  <= rx_bits + 1'b1;
                        if (rx_bits == 3'd7)
                            rx_state <= RX_STOP;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: begin
                    if (rx_cnt == CNT_W'(BIT_CLKS - 1)) begin
                        rx_state <= RX_IDLE;
                        if (!rx_in) begin
                            framing_error_o <= 1'b1;   // byte dropped
                        end else if (pending_write) begin
                            bus.write_data <= rx_shift;
                            bus.reg_write  <= 1'b1;
                            pending_write  <= 1'b0;
                        end else begin
                            bus.reg_address <= rx_shift[6:0];
                            pending_write   <= rx_shift[7];
                            bus.reg_read    <= ~rx_shift[7];
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // reply serializer, loaded in the reg_read cycle
    always_ff @(posedge mainclk_buf) begin
        if (reset_i) begin
            tx_shift <= '1;
            tx_cnt   <= '0;
            tx_left  <= '0;
        end else if (bus.reg_read) begin
            tx_shift <= {1'b1, bus.read_data, 1'b0};
            tx_cnt   <= '0;
            tx_left  <= 4'd10;
        end else if (tx_left != 4'd0) begin
            if (tx_cnt == CNT_W'(BIT_CLKS - 1)) begin
                tx_cnt   <= '0;
                tx_shift <= {1'b1, tx_shift[9:1]};
                tx_left  <= tx_left - 1'b1;
            end else begin
                tx_cnt <= tx_cnt + 1'b1;
            end
        end
    end

    a_one_strobe: assert property (@(posedge mainclk_buf) disable iff (reset_i)
        !(bus.reg_read && bus.reg_write));

endmodule

// ==== testbench/sonata_tb.sv ====
// sonata_tb: clock, reset, UART host tasks, reference functions, checks and summary
`include "sonata_settings.svh"

module sonata_tb;
    localparam int BIT_CLKS = `SONATA_BIT_RATE;
    localparam int WAIT_MAX = 40 * BIT_CLKS;   // cycles allowed before a reply start bit
    localparam int POLL_MAX = 200;             // STATUS reads allowed per memory test

    logic        mainclk_buf = 1'b0;
    logic        reset_i;
    logic        ss2_rx_i;
    logic        ss2_tx_o;
    logic [7:0]  usrsw_i;
    logic [4:0]  navsw_i;
    logic [2:0]  selsw_i;
    logic [7:0]  usrled_o;
    logic [8:0]  cherierr_o;
    logic        led_legacy_o;
    logic        led_cheri_o;
    logic        led_halted_o;
    logic        led_bootok_o;
    integer      seed = 32'hae91;
    int          errors = 0;
    int          checks = 0;
    logic        timed_out = 1'b0;
    string       timeout_msg;
    logic [15:0] shadow [0:255];   // host view of the memory
    logic [7:0]  man_addrs [$];

    always #4 mainclk_buf = ~mainclk_buf;

    sonata_top sonata_top_i (
        .mainclk_buf, .reset_i, .ss2_rx_i, .ss2_tx_o, .usrsw_i, .navsw_i, .selsw_i,
        .usrled_o, .cherierr_o, .led_legacy_o, .led_cheri_o, .led_halted_o, .led_bootok_o
    );

    // expected memory word for the address pattern
    function automatic logic [15:0] addr_word(input logic [7:0] a);
        return {~a, a};
    endfunction

    // expected memory word after a number of steps of the galois LFSR
    function automatic logic [15:0] lfsr_word(input int steps);
        logic [15:0] v;
        v = `SONATA_LFSR_SEED;
        for (int i = 0; i < steps; i++)
            v = {1'b0, v[15:1]} ^ (v[0] ? `SONATA_LFSR_TAPS : 16'h0000);
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time %0t %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
        end
    endtask

    // hand the failure to the timeout process and park here
    task automatic stall(input string msg);
        timeout_msg = msg;
        timed_out   = 1'b1;
        forever @(posedge mainclk_buf);
    endtask

    always @(posedge mainclk_buf) begin
        if (timed_out) begin
            $display("timeout: %s", timeout_msg);
            $display("checks run: %0d, errors: %0d", checks, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // one 8N1 frame, lsb first
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge mainclk_buf);
            ss2_rx_i <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge mainclk_buf);
        end
        @(posedge mainclk_buf);
        ss2_rx_i <= 1'b1;   // line back to idle
    endtask

    task automatic recv_byte(output logic [7:0] data);
        int waited;
        waited = 0;
        data   = 8'h00;
        @(negedge mainclk_buf);
        while (ss2_tx_o !== 1'b0 && waited < WAIT_MAX) begin
            @(negedge mainclk_buf);
            waited++;
        end
        if (waited >= WAIT_MAX)
            stall("no reply start bit from the DUT");
        repeat (BIT_CLKS / 2) @(negedge mainclk_buf);   // middle of start bit
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge mainclk_buf);
            data[i] = ss2_tx_o;
        end
        repeat (BIT_CLKS) @(negedge mainclk_buf);
        if (ss2_tx_o !== 1'b1) begin
            errors++;
            $display("reply byte ending at time %0t has a low stop bit", $time);
        end
        repeat (BIT_CLKS / 2) @(negedge mainclk_buf);   // let the stop bit finish
    endtask

    task automatic write_reg(input logic [6:0] addr, input logic [7:0] data);
        send_frame({1'b1, addr}, 1'b1);
        send_frame(data, 1'b1);
    endtask

    task automatic read_reg(input logic [6:0] addr, output logic [7:0] data);
        send_frame({1'b0, addr}, 1'b1);
        recv_byte(data);
    endtask

    task automatic man_write(input logic [7:0] addr, input logic [15:0] data);
        write_reg(`SONATA_REG_MAN_ADDR, addr);
        write_reg(`SONATA_REG_MAN_WDATA_LO, data[7:0]);
        write_reg(`SONATA_REG_MAN_WDATA_HI, data[15:8]);
        write_reg(`SONATA_REG_MAN_CMD, 8'h01);
    endtask

    task automatic man_read(input logic [7:0] addr, output logic [15:0] data);
        logic [7:0] lo;
        logic [7:0] hi;
        write_reg(`SONATA_REG_MAN_ADDR, addr);
        write_reg(`SONATA_REG_MAN_CMD, 8'h02);
        read_reg(`SONATA_REG_MAN_RDATA_LO, lo);
        read_reg(`SONATA_REG_MAN_RDATA_HI, hi);
        data = {hi, lo};
    endtask

    // start an automatic test with the memory handed over, wait until busy drops
    task automatic run_auto_test(input logic [7:0] start, input logic [7:0] stop,
                                 input logic lfsr, output logic [7:0] status);
        int polls;
        polls  = 0;
        status = 8'h04;
        write_reg(`SONATA_REG_ADDR_START, start);
        write_reg(`SONATA_REG_ADDR_STOP, stop);
        write_reg(`SONATA_REG_CTRL, lfsr ? 8'h50 : 8'h10);
        while (status[2] && polls < POLL_MAX) begin
            read_reg(`SONATA_REG_STATUS, status);
            polls++;
        end
        if (status[2])
            stall("memory test still busy after the polling limit");
    endtask

    initial begin
        logic [7:0]  rd;
        logic [7:0]  led0;
        logic [7:0]  led1;
        logic [7:0]  led2;
        logic [7:0]  start;
        logic [7:0]  stop;
        logic [7:0]  a;
        logic [15:0] sw;
        logic [15:0] word;
        int          len;
        int          off;

        ss2_rx_i <= 1'b1;
        reset_i  <= 1'b1;
        usrsw_i  <= 8'($random(seed));
        navsw_i  <= 5'($random(seed));
        selsw_i  <= 3'($random(seed));
        repeat (5) @(posedge mainclk_buf);
        reset_i <= 1'b0;
        @(posedge mainclk_buf);
        sw = {usrsw_i, navsw_i, selsw_i};

        read_reg(`SONATA_REG_ID, rd);
        check_val("id", 32'(rd), 32'h5A);
        read_reg(`SONATA_REG_SW_LO, rd);
        check_val("switches low", 32'(rd), 32'(sw[7:0]));
        read_reg(`SONATA_REG_SW_HI, rd);
        check_val("switches high", 32'(rd), 32'(sw[15:8]));

        // LED word shown in test mode
        led0 = 8'($random(seed));
        led1 = 8'($random(seed));
        led2 = 8'($random(seed) & 32'h1F);
        write_reg(`SONATA_REG_LED0, led0);
        write_reg(`SONATA_REG_LED1, led1);
        write_reg(`SONATA_REG_LED2, led2);
        write_reg(`SONATA_REG_CTRL, 8'h0A);
        repeat (2) @(negedge mainclk_buf);
        check_val("usrled_o", 32'(usrled_o), 32'(led0));
        check_val("cherierr_o", 32'(cherierr_o), 32'({led2[0], led1}));
        check_val("led_legacy_o", 32'(led_legacy_o), 32'(led2[1]));
        check_val("led_cheri_o", 32'(led_cheri_o), 32'(led2[2]));
        check_val("led_halted_o", 32'(led_halted_o), 32'(led2[3]));
        check_val("led_bootok_o", 32'(led_bootok_o), 32'(led2[4]));
        write_reg(`SONATA_REG_CTRL, 8'h09);
        repeat (2) @(negedge mainclk_buf);
        check_val("usrled_o[1]", 32'(usrled_o[1]), 32'h1);
        check_val("cherierr_o", 32'(cherierr_o), 32'h0);
        check_val("led_legacy_o", 32'(led_legacy_o), 32'h0);
        check_val("led_cheri_o", 32'(led_cheri_o), 32'h0);
        check_val("led_halted_o", 32'(led_halted_o), 32'h0);
        check_val("led_bootok_o", 32'(led_bootok_o), 32'h0);

        // manual window against the shadow copy
        for (int i = 0; i < 6; i++) begin
            a    = 8'($random(seed));
            word = 16'($random(seed));
            man_write(a, word);
            shadow[a] = word;
            man_addrs.push_back(a);
        end
        foreach (man_addrs[i]) begin
            man_read(man_addrs[i], word);
            check_val("manual read data", 32'(word), 32'(shadow[man_addrs[i]]));
        end

        // automatic test, address pattern
        len   = $random(seed) & 15;
        start = 8'($random(seed));
        stop  = (int'(start) + len > 255) ? 8'hFF : start + 8'(len);
        run_auto_test(start, stop, 1'b0, rd);
        check_val("status", 32'(rd), 32'h01);
        read_reg(`SONATA_REG_ERRORS, rd);
        check_val("errors", 32'(rd), 32'h0);
        read_reg(`SONATA_REG_ITERATIONS, rd);
        check_val("iterations", 32'(rd), 32'h1);
        @(negedge mainclk_buf);
        check_val("usrled_o[4]", 32'(usrled_o[4]), 32'h1);
        write_reg(`SONATA_REG_CTRL, 8'h08);   // memory back to the host
        for (int i = 0; i < 4; i++) begin
            off = ($random(seed) & 32'h7FFF) % (int'(stop) - int'(start) + 1);
            a   = start + 8'(off);
            man_read(a, word);
            check_val("address pattern word", 32'(word), 32'(addr_word(a)));
        end

        // automatic test, LFSR pattern
        len   = $random(seed) & 15;
        start = 8'($random(seed));
        stop  = (int'(start) + len > 255) ? 8'hFF : start + 8'(len);
        run_auto_test(start, stop, 1'b1, rd);
        check_val("status", 32'(rd), 32'h01);
        read_reg(`SONATA_REG_ITERATIONS, rd);
        check_val("iterations", 32'(rd), 32'h2);
        write_reg(`SONATA_REG_CTRL, 8'h48);
        man_read(start, word);
        check_val("first lfsr word", 32'(word), 32'(lfsr_word(0)));
        man_read(stop, word);
        check_val("last lfsr word", 32'(word), 32'(lfsr_word(int'(stop) - int'(start))));

        // byte with a low stop bit is dropped
        send_frame(8'hA5, 1'b0);
        repeat (2 * BIT_CLKS) @(posedge mainclk_buf);
        @(negedge mainclk_buf);
        check_val("usrled_o[7]", 32'(usrled_o[7]), 32'h1);
        read_reg(`SONATA_REG_ID, rd);
        check_val("id after framing error", 32'(rd), 32'h5A);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
